// ==== timer_pkg.sv ====
package timer_pkg;

    // ----------------------------------------
    // Sizing
    // ----------------------------------------

    localparam int num_timers   = 4;
    localparam int timer_width  = 32;
    localparam int index_width  = $clog2(num_timers);
    localparam int offset_width = 2;

    // ----------------------------------------
    // Register map, per timer
    // ----------------------------------------

    // Offset 0 writes the reload value and reads the live count
    localparam logic [offset_width-1:0] reg_count   = 2'd0;
    localparam logic [offset_width-1:0] reg_control = 2'd1;
    // Global register that reads the same for every timer index
    localparam logic [offset_width-1:0] reg_status  = 2'd2;

    // Control register bits
    localparam int ctrl_enable     = 0;
    localparam int ctrl_irq_enable = 1;
    localparam int ctrl_width      = 2;

    // ----------------------------------------
    // Bus payloads
    // ----------------------------------------

    typedef struct packed {
        logic                    write;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
        logic [timer_width-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [timer_width-1:0] rdata;
    } cpu_rsp_t;

    // ----------------------------------------
    // Internal buses
    // ----------------------------------------

    // Broadcast to all channels and qualified by the per-timer select
    typedef struct packed {
        logic                   write_reload;
        logic                   write_control;
        logic [timer_width-1:0] data;
    } timer_cmd_t;

    typedef struct packed {
        logic [timer_width-1:0] count;
        logic [ctrl_width-1:0]  control;
        logic                   irq;
    } timer_state_t;

endpackage

// ==== bus_decode.sv ====
`timescale 1ns/1ps

module bus_decode (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  req_valid,
    input  timer_pkg::cpu_req_t                   req,
    output logic                                  req_ready,
    input  logic                                  rsp_done,
    output timer_pkg::timer_cmd_t                 cmd,
    output logic [timer_pkg::num_timers-1:0]      sel,
    output logic                                  issue,
    output logic [timer_pkg::index_width-1:0]     rd_index,
    output logic [timer_pkg::offset_width-1:0]    rd_offset,
    output logic                                  write_op
);

    logic                busy;
    logic                accept;
    timer_pkg::cpu_req_t req_q;
    logic                write_reload;
    logic                write_control;

    // ----------------------------------------
    // Acceptance
    // ----------------------------------------

    // One transaction in flight until the response is taken
    assign req_ready = !busy;
    assign accept    = req_valid && !busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            issue <= 1'b0;
        end else begin
            issue <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (rsp_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // ----------------------------------------
    // Strobes
    // ----------------------------------------

    assign write_reload  = req_q.write && (req_q.offset == timer_pkg::reg_count);
    assign write_control = req_q.write && (req_q.offset == timer_pkg::reg_control);

    // Status and unmapped writes select no timer
    always_comb begin
        sel = '0;
        if (issue && (write_reload || write_control)) begin
            sel[req_q.index] = 1'b1;
        end
    end

    always_comb begin
        cmd.write_reload  = write_reload;
        cmd.write_control = write_control;
        cmd.data          = req_q.wdata;
    end

    assign rd_index  = req_q.index;
    assign rd_offset = req_q.offset;
    assign write_op  = req_q.write;

    // At most one channel written per transaction
    assert property (@(posedge clk) disable iff (!reset_n) $onehot0(sel));

endmodule

// ==== one_shot_timer.sv ====
`timescale 1ns/1ps

module one_shot_timer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sel,
    input  timer_pkg::timer_cmd_t   cmd,
    output timer_pkg::timer_state_t state
);

    logic [timer_pkg::timer_width-1:0] reload;
    logic [timer_pkg::timer_width-1:0] count;
    logic [timer_pkg::ctrl_width-1:0]  control;
    logic                              irq_flag;
    logic                              running;
    logic                              control_write;

    // ----------------------------------------
    // Qualifiers
    // ----------------------------------------

    assign control_write = sel && cmd.write_control;

    // Stops counting once expired and stays so until the next control write
    assign running = control[timer_pkg::ctrl_enable] && !irq_flag;

    // ----------------------------------------
    // Channel registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reload   <= '0;
            count    <= '0;
            control  <= '0;
            irq_flag <= 1'b0;
        end else if (sel) begin
            // No counting in a cycle the bus writes this channel
            if (cmd.write_reload) begin
                reload <= cmd.data;
            end
            if (cmd.write_control) begin
                control  <= cmd.data[timer_pkg::ctrl_width-1:0];
                count    <= reload;
                // Acknowledge of a pending interrupt
                irq_flag <= 1'b0;
            end
        end else if (running) begin
            if (count != '0) begin
                count <= count - 1'b1;
            end else if (control[timer_pkg::ctrl_irq_enable]) begin
                irq_flag <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Visible state
    // ----------------------------------------

    always_comb begin
        state.count   = count;
        state.control = control;
        state.irq     = irq_flag;
    end

    // Only a control write may raise the count
    assert property (@(posedge clk) disable iff (!reset_n)
        !control_write |=> (count <= $past(count)));

endmodule

// ==== bus_response.sv ====
`timescale 1ns/1ps

module bus_response (
    input  logic                                                  clk,
    input  logic                                                  reset_n,
    input  logic                                                  issue,
    input  logic [timer_pkg::index_width-1:0]                     rd_index,
    input  logic [timer_pkg::offset_width-1:0]                    rd_offset,
    input  logic                                                  write_op,
    input  timer_pkg::timer_state_t [timer_pkg::num_timers-1:0]   states,
    output logic                                                  rsp_valid,
    output timer_pkg::cpu_rsp_t                                   rsp,
    input  logic                                                  rsp_ready,
    output logic                                                  rsp_done,
    output logic                                                  irq
);

    logic [timer_pkg::num_timers-1:0]  irq_vec;
    logic [timer_pkg::timer_width-1:0] rd_data;

    // Pending flags of all channels
    always_comb begin
        for (int i = 0; i < timer_pkg::num_timers; i++) begin
            irq_vec[i] = states[i].irq;
        end
    end

    // ----------------------------------------
    // Read data select
    // ----------------------------------------

    always_comb begin
        rd_data = '0;
        if (!write_op) begin
            case (rd_offset)
                timer_pkg::reg_count: begin
                    rd_data = states[rd_index].count;
                end
                timer_pkg::reg_control: begin
                    rd_data[timer_pkg::ctrl_width-1:0] = states[rd_index].control;
                end
                timer_pkg::reg_status: begin
                    rd_data[timer_pkg::num_timers-1:0] = irq_vec;
                end
                // Unmapped offset reads zero
                default: begin
                    rd_data = '0;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Response handshake
    // ----------------------------------------

    assign rsp_done = rsp_valid && rsp_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rsp_valid <= 1'b0;
            irq       <= 1'b0;
        end else begin
            irq <= |irq_vec;
            if (issue) begin
                rsp_valid <= 1'b1;
            end else if (rsp_done) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Captured once per transaction and held under back-pressure
    always_ff @(posedge clk) begin
        if (issue) begin
            rsp.rdata <= rd_data;
        end
    end

    // Stalled response keeps its value
    assert property (@(posedge clk) disable iff (!reset_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)));

    // No new issue while a response is still outstanding
    assert property (@(posedge clk) disable iff (!reset_n)
        issue |-> (!rsp_valid || rsp_done));

endmodule

// ==== timer_block.sv ====
`timescale 1ns/1ps

module timer_block (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                req_valid,
    input  timer_pkg::cpu_req_t req,
    output logic                req_ready,
    output logic                rsp_valid,
    output timer_pkg::cpu_rsp_t rsp,
    input  logic                rsp_ready,
    output logic                irq
);

    timer_pkg::timer_cmd_t                                cmd;
    logic [timer_pkg::num_timers-1:0]                     sel;
    logic                                                 issue;
    logic [timer_pkg::index_width-1:0]                    rd_index;
    logic [timer_pkg::offset_width-1:0]                   rd_offset;
    logic                                                 write_op;
    logic                                                 rsp_done;
    timer_pkg::timer_state_t [timer_pkg::num_timers-1:0]  states;

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    bus_decode u_decode (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_done  (rsp_done),
        .cmd       (cmd),
        .sel       (sel),
        .issue     (issue),
        .rd_index  (rd_index),
        .rd_offset (rd_offset),
        .write_op  (write_op)
    );

    // ----------------------------------------
    // Timer channels
    // ----------------------------------------

    for (genvar i = 0; i < timer_pkg::num_timers; i++) begin : g_timer
        one_shot_timer u_timer (
            .clk     (clk),
            .reset_n (reset_n),
            .sel     (sel[i]),
            .cmd     (cmd),
            .state   (states[i])
        );
    end

    // ----------------------------------------
    // Response and interrupt
    // ----------------------------------------

    bus_response u_response (
        .clk       (clk),
        .reset_n   (reset_n),
        .issue     (issue),
        .rd_index  (rd_index),
        .rd_offset (rd_offset),
        .write_op  (write_op),
        .states    (states),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .rsp_done  (rsp_done),
        .irq       (irq)
    );

endmodule

// ==== tb_timer_block.sv ====
`timescale 1ns/1ps

module tb_timer_block;

    logic                clk;
    logic                reset_n;
    logic                req_valid;
    timer_pkg::cpu_req_t req;
    logic                req_ready;
    logic                rsp_valid;
    timer_pkg::cpu_rsp_t rsp;
    logic                rsp_ready;
    logic                irq;

    // Reference model of the register file
    logic [timer_pkg::timer_width-1:0] model_reload [timer_pkg::num_timers];
    logic [timer_pkg::timer_width-1:0] model_count  [timer_pkg::num_timers];
    logic [timer_pkg::ctrl_width-1:0]  model_ctrl   [timer_pkg::num_timers];
    logic [timer_pkg::num_timers-1:0]  model_irq;

    logic [31:0] lcg_state;
    int          line_no;

    timer_block u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .irq       (irq)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] seed);
        return seed * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_rsp(input string name, input timer_pkg::cpu_rsp_t actual,
                             input timer_pkg::cpu_rsp_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h (pattern line %0d)",
                                name, actual.rdata, expected.rdata, line_no));
        end
    endtask

    task automatic check_rsp_bound(input timer_pkg::cpu_rsp_t actual,
                                   input timer_pkg::cpu_rsp_t limit);
        if ($isunknown(actual.rdata) || actual.rdata > limit.rdata) begin
            abort_run($sformatf("[ERROR] rsp.rdata: got %h, expected at most %h (pattern line %0d)",
                                actual.rdata, limit.rdata, line_no));
        end
    endtask

    task automatic check_irq(input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] irq: got %h, expected %h (pattern line %0d)",
                                actual, expected, line_no));
        end
    endtask

    task automatic check_handshake(input string name, input logic actual,
                                   input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h (pattern line %0d)",
                                name, actual, expected, line_no));
        end
    endtask

    // One request and its response with optional rsp_ready stall cycles
    task automatic bus_access(input logic write, input logic [1:0] index,
                              input logic [1:0] offset, input logic [31:0] wdata,
                              input int stall, output timer_pkg::cpu_rsp_t result);
        int                  cycles;
        timer_pkg::cpu_rsp_t held;
        req.write  = write;
        req.index  = index;
        req.offset = offset;
        req.wdata  = wdata;
        req_valid  = 1'b1;
        rsp_ready  = (stall == 0);
        cycles     = 0;
        while (req_ready !== 1'b1) begin
            if (cycles >= 50) begin
                abort_run($sformatf("timeout: request on pattern line %0d never accepted",
                                    line_no));
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        req       = '0;
        cycles    = 0;
        while (rsp_valid !== 1'b1) begin
            check_handshake("req_ready", req_ready, 1'b0);
            if (cycles >= 50) begin
                abort_run($sformatf("timeout: no response for pattern line %0d", line_no));
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        held = rsp;
        repeat (stall) begin
            @(posedge clk);
            #2;
            if (rsp_valid !== 1'b1) begin
                abort_run($sformatf("response withdrawn before acceptance on pattern line %0d",
                                    line_no));
            end
            check_handshake("req_ready", req_ready, 1'b0);
            check_rsp("rsp.rdata (stalled)", rsp, held);
        end
        rsp_ready = 1'b1;
        @(posedge clk);
        #2;
        // Response taken, next request may go in this cycle
        check_handshake("rsp_valid", rsp_valid, 1'b0);
        check_handshake("req_ready", req_ready, 1'b1);
        result = held;
    endtask

    task automatic wait_irq_high(input int limit);
        int cycles;
        cycles = 0;
        while (irq !== 1'b1) begin
            if (cycles >= limit) begin
                abort_run($sformatf("timeout: irq did not rise within %0d cycles (line %0d)",
                                    limit, line_no));
            end
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    // ----------------------------------------
    // Model
    // ----------------------------------------

    task automatic model_write(input int index, input logic [1:0] offset,
                               input logic [31:0] data);
        if (offset == timer_pkg::reg_count) begin
            model_reload[index] = data;
        end else if (offset == timer_pkg::reg_control) begin
            model_ctrl[index]  = data[timer_pkg::ctrl_width-1:0];
            model_count[index] = model_reload[index];
            model_irq[index]   = 1'b0;
        end
    endtask

    // A running count is only known once the timer has expired
    function automatic logic model_known(input int index, input logic [1:0] offset);
        return !(offset == timer_pkg::reg_count && model_ctrl[index][timer_pkg::ctrl_enable]
                 && !model_irq[index]);
    endfunction

    function automatic timer_pkg::cpu_rsp_t model_read(input int index,
                                                       input logic [1:0] offset);
        timer_pkg::cpu_rsp_t expected;
        expected = '0;
        case (offset)
            timer_pkg::reg_count: begin
                if (!model_ctrl[index][timer_pkg::ctrl_enable]) begin
                    expected.rdata = model_count[index];
                end
            end
            timer_pkg::reg_control: begin
                expected.rdata[timer_pkg::ctrl_width-1:0] = model_ctrl[index];
            end
            timer_pkg::reg_status: begin
                expected.rdata[timer_pkg::num_timers-1:0] = model_irq;
            end
            default: begin
                expected.rdata = '0;
            end
        endcase
        return expected;
    endfunction

    // ----------------------------------------
    // Pattern replay
    // ----------------------------------------

    initial begin
        int                  fd;
        int                  got;
        int                  stall;
        string               text;
        logic [31:0]         op;
        logic [31:0]         index;
        logic [31:0]         offset;
        logic [31:0]         arg;
        logic [31:0]         exp_val;
        timer_pkg::cpu_rsp_t result;
        timer_pkg::cpu_rsp_t expected;
        clk       = 1'b0;
        reset_n   = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        lcg_state = 32'h33e8_1bb3;
        line_no   = 0;
        model_irq = '0;
        for (int i = 0; i < timer_pkg::num_timers; i++) begin
            model_reload[i] = '0;
            model_count[i]  = '0;
            model_ctrl[i]   = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;
        @(posedge clk);
        #2;
        check_handshake("req_ready", req_ready, 1'b1);
        check_handshake("rsp_valid", rsp_valid, 1'b0);

        fd = $fopen("timer_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("could not open timer_patterns.txt");
        end
        while (!$feof(fd)) begin
            got = $fgets(text, fd);
            line_no++;
            if (got == 0 || text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(text, "%h %h %h %h %h", op, index, offset, arg, exp_val) != 5) begin
                abort_run($sformatf("pattern line %0d is malformed", line_no));
            end
            expected = '0;
            case (op)
                // Idle cycles
                0: begin
                    repeat (arg) begin
                        @(posedge clk);
                        #2;
                    end
                end
                // Write whose response data must be zero
                1: begin
                    bus_access(1'b1, index[1:0], offset[1:0], arg, 0, result);
                    check_rsp("rsp.rdata", result, expected);
                    model_write(index[1:0], offset[1:0], arg);
                end
                2: begin
                    bus_access(1'b0, index[1:0], offset[1:0], '0, 0, result);
                    expected.rdata = exp_val;
                    check_rsp("rsp.rdata", result, expected);
                end
                3: begin
                    bus_access(1'b0, index[1:0], offset[1:0], '0, 0, result);
                    expected.rdata = exp_val;
                    check_rsp_bound(result, expected);
                end
                4, 7: begin
                    if (!model_known(index[1:0], offset[1:0])) begin
                        abort_run($sformatf("pattern line %0d reads an unpredictable count",
                                            line_no));
                    end
                    stall = 0;
                    if (op == 7) begin
                        lcg_state = lcg_next(lcg_state);
                        stall     = int'(lcg_state[17:16]) + 1;
                    end
                    bus_access(1'b0, index[1:0], offset[1:0], '0, stall, result);
                    check_rsp("rsp.rdata", result, model_read(index[1:0], offset[1:0]));
                end
                // Expired timers given as a mask in the last column
                5: begin
                    wait_irq_high(arg);
                    model_irq = model_irq | exp_val[timer_pkg::num_timers-1:0];
                end
                6: begin
                    check_irq(irq, 1'b0);
                end
                default: begin
                    abort_run($sformatf("unknown operation on pattern line %0d", line_no));
                end
            endcase
        end
        $fclose(fd);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== timer_patterns.txt ====
# Columns, all hex: op index offset arg expected
# op 0 idle arg cycles, 1 write arg, 2 read equal to expected, 3 read at most expected,
# op 4 read against model, 5 wait irq within arg cycles then mark expected mask pending,
# op 6 irq low, 7 read against model with rsp_ready stalls
# Reset values
6 0 0 0 0
4 0 0 0 0
4 0 1 0 0
4 1 0 0 0
4 1 1 0 0
4 2 0 0 0
4 2 1 0 0
4 3 0 0 0
4 3 1 0 0
4 0 2 0 0
# Reload write alone leaves the count
1 1 0 1234 0
2 1 0 0 0
1 1 1 0 0
2 1 0 0 1234
4 1 1 0 0
# Timer 0 one-shot with interrupt
1 0 0 10 0
1 0 1 3 0
5 0 0 20 1
4 0 0 0 0
4 0 2 0 0
2 1 0 0 1234
4 1 1 0 0
# Acknowledge timer 0
1 0 1 0 0
6 0 0 0 0
3 0 0 0 10
# Timers 2 and 3 expire together
1 2 0 8 0
1 3 0 8 0
1 2 1 3 0
1 3 1 3 0
5 0 0 20 c
0 0 0 4 0
4 0 2 0 0
4 3 0 0 0
1 2 1 0 0
4 0 2 0 0
5 0 0 2 0
1 3 1 0 0
6 0 0 0 0
4 0 2 0 0
# Timer 1 counts down with interrupt disabled
1 1 0 20 0
1 1 1 1 0
0 0 0 30 0
2 1 0 0 0
6 0 0 0 0
4 1 1 0 0
4 0 2 0 0
# Stalled responses, unmapped offset, ignored writes
7 0 0 0 0
7 1 1 0 0
7 0 2 0 0
7 2 3 0 0
1 0 3 ffffffff 0
1 0 2 ffffffff 0
7 0 0 0 0
7 0 1 0 0
7 0 3 0 0
7 3 0 0 0
7 2 1 0 0
6 0 0 0 0

// ==== verilog.f ====
timer_pkg.sv
bus_decode.sv
one_shot_timer.sv
bus_response.sv
timer_block.sv
tb_timer_block.sv

// ==== Bender.yml ====
package:
  name: timer_block

sources:
  - files:
      - timer_pkg.sv
      - bus_decode.sv
      - one_shot_timer.sv
      - bus_response.sv
      - timer_block.sv
  - target: test
    files:
      - tb_timer_block.sv
